// File: list.f
source/dbg_pkg.sv
source/dm_regs.sv
source/halt_ctrl.sv
source/sba_engine.sv
source/sys_rstgen.sv
source/debug_system.sv
verification/tb_debug_system.sv

// File: run.sh
#!/bin/sh
# compile with Verilator and run, exit status follows the simulation
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -f list.f --top-module tb_debug_system &&
  ./obj_dir/Vtb_debug_system || exit 1

// File: source/dbg_pkg.sv
package dbg_pkg;

  localparam int unsigned NrHarts      = 4;
  localparam int unsigned BusWidth     = 32;
  localparam int unsigned DmiAddrWidth = 7;

  typedef logic [DmiAddrWidth-1:0]    dmi_addr_t;
  typedef logic [BusWidth-1:0]        bus_word_t;
  typedef logic [$clog2(NrHarts)-1:0] hart_sel_t;
  typedef logic [NrHarts-1:0]         hart_vec_t;

  // debug module register map
  localparam dmi_addr_t AddrData0      = 7'h04;
  localparam dmi_addr_t AddrDmcontrol  = 7'h10;
  localparam dmi_addr_t AddrDmstatus   = 7'h11;
  localparam dmi_addr_t AddrSbcs       = 7'h38;
  localparam dmi_addr_t AddrSbaddress0 = 7'h39;
  localparam dmi_addr_t AddrSbdata0    = 7'h3C;

  typedef enum logic [1:0] {
    NOP   = 2'd0,
    READ  = 2'd1,
    WRITE = 2'd2
  } dmi_op_e;

  typedef enum logic [1:0] {
    IDLE,
    REQUEST,
    WAIT_RVALID
  } sba_state_e;

  typedef struct packed {
    dmi_op_e   op;
    dmi_addr_t addr;
    bus_word_t data;
  } dmi_req_t;

  typedef struct packed {
    bus_word_t data;
    logic      error;
  } dmi_resp_t;

  // one access handed from the register block to the bus engine
  typedef struct packed {
    logic      start;
    logic      we;
    bus_word_t addr;
    bus_word_t wdata;
    logic      autoincrement;
  } sba_cmd_t;

  typedef struct packed {
    logic      busy;
    logic      done;
    bus_word_t rdata;
    bus_word_t next_addr;
  } sba_stat_t;

  typedef struct packed {
    logic                    req;
    logic                    we;
    bus_word_t               addr;
    logic [BusWidth/8-1:0]   be;
    bus_word_t               wdata;
  } sbus_req_t;

endpackage

// File: source/debug_system.sv
`timescale 1ns/10ps

module debug_system (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               test_en_i,
  input  logic               dmi_req_valid_i,
  input  dbg_pkg::dmi_req_t  dmi_req_i,
  output logic               dmi_resp_valid_o,
  output dbg_pkg::dmi_resp_t dmi_resp_o,
  input  dbg_pkg::hart_vec_t halted_i,
  output dbg_pkg::hart_vec_t debug_req_o,
  output dbg_pkg::sbus_req_t sbus_req_o,
  input  logic               sbus_gnt_i,
  input  logic               sbus_rvalid_i,
  input  dbg_pkg::bus_word_t sbus_rdata_i,
  output logic               ndmreset_no
);
  import dbg_pkg::*;

  hart_sel_t hartsel;
  logic      haltreq;
  logic      ndmreset;
  logic      anyhalted;
  logic      allhalted;
  sba_cmd_t  sba_cmd;
  sba_stat_t sba_stat;

  dm_regs i_dm_regs (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .dmi_req_valid_i  (dmi_req_valid_i),
    .dmi_req_i        (dmi_req_i),
    .dmi_resp_valid_o (dmi_resp_valid_o),
    .dmi_resp_o       (dmi_resp_o),
    .hartsel_o        (hartsel),
    .haltreq_o        (haltreq),
    .ndmreset_o       (ndmreset),
    .anyhalted_i      (anyhalted),
    .allhalted_i      (allhalted),
    .sba_cmd_o        (sba_cmd),
    .sba_stat_i       (sba_stat)
  );

  halt_ctrl i_halt_ctrl (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .hartsel_i   (hartsel),
    .haltreq_i   (haltreq),
    .halted_i    (halted_i),
    .debug_req_o (debug_req_o),
    .anyhalted_o (anyhalted),
    .allhalted_o (allhalted)
  );

  // system bus access stays on the native req/gnt bus
  sba_engine i_sba_engine (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .cmd_i         (sba_cmd),
    .stat_o        (sba_stat),
    .sbus_req_o    (sbus_req_o),
    .sbus_gnt_i    (sbus_gnt_i),
    .sbus_rvalid_i (sbus_rvalid_i),
    .sbus_rdata_i  (sbus_rdata_i)
  );

  sys_rstgen i_sys_rstgen (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .ndmreset_i (ndmreset),
    .test_en_i  (test_en_i),
    .rst_no     (ndmreset_no)
  );

endmodule

// File: source/dm_regs.sv
`timescale 1ns/10ps

module dm_regs (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               dmi_req_valid_i,
  input  dbg_pkg::dmi_req_t  dmi_req_i,
  output logic               dmi_resp_valid_o,
  output dbg_pkg::dmi_resp_t dmi_resp_o,
  output dbg_pkg::hart_sel_t hartsel_o,
  output logic               haltreq_o,
  output logic               ndmreset_o,
  input  logic               anyhalted_i,
  input  logic               allhalted_i,
  output dbg_pkg::sba_cmd_t  sba_cmd_o,
  input  dbg_pkg::sba_stat_t sba_stat_i
);
  import dbg_pkg::*;

  // dmcontrol fields
  logic      haltreq_q;
  logic      ndmreset_q;
  logic      dmactive_q;
  hart_sel_t hartsel_q;
  // sbcs fields
  logic      sbreadonaddr_q;
  logic      sbautoinc_q;
  logic      sbreadondata_q;
  logic      sberror_q;
  bus_word_t data0_q;
  bus_word_t sbaddress_q;
  bus_word_t sbdata_q;
  logic      resp_valid_q;
  dmi_resp_t resp_q;
  logic      sba_start_q;
  logic      sba_we_q;
  bus_word_t sba_addr_q;
  bus_word_t sba_wdata_q;
  logic      is_read;
  logic      is_write;
  logic      addr_err;
  bus_word_t rdata;
  logic      sba_kick;
  logic      kick_we;
  bus_word_t kick_addr;
  bus_word_t kick_wdata;
  logic      collide;

  always_comb begin
    is_read  = dmi_req_valid_i && (dmi_req_i.op == READ);
    is_write = dmi_req_valid_i && (dmi_req_i.op == WRITE);
    rdata    = '0;
    addr_err = 1'b0;
    case (dmi_req_i.addr)
      AddrData0:      rdata = data0_q;
      AddrDmcontrol: begin
        rdata[31]    = haltreq_q;
        rdata[17:16] = hartsel_q;
        rdata[1]     = ndmreset_q;
        rdata[0]     = dmactive_q;
      end
      AddrDmstatus: begin
        rdata[9]   = allhalted_i;
        rdata[8]   = anyhalted_i;
        rdata[3:0] = 4'd2;
      end
      AddrSbcs: begin
        rdata[21] = sba_stat_i.busy;
        rdata[20] = sbreadonaddr_q;
        rdata[16] = sbautoinc_q;
        rdata[15] = sbreadondata_q;
        rdata[12] = sberror_q;
      end
      AddrSbaddress0: rdata = sbaddress_q;
      AddrSbdata0:    rdata = sbdata_q;
      default:        addr_err = 1'b1;
    endcase

    // which request kicks off a bus access
    sba_kick   = 1'b0;
    kick_we    = 1'b0;
    kick_addr  = sbaddress_q;
    kick_wdata = sbdata_q;
    if (is_write && (dmi_req_i.addr == AddrSbaddress0) && sbreadonaddr_q) begin
      sba_kick  = 1'b1;
      kick_addr = dmi_req_i.data;
    end else if (is_write && (dmi_req_i.addr == AddrSbdata0)) begin
      sba_kick   = 1'b1;
      kick_we    = 1'b1;
      kick_wdata = dmi_req_i.data;
    end else if (is_read && (dmi_req_i.addr == AddrSbdata0) && sbreadondata_q) begin
      sba_kick = 1'b1;
    end
    // start already in flight counts as busy too
    collide = sba_kick && (sba_stat_i.busy || sba_start_q);
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      resp_valid_q   <= 1'b0;
      resp_q         <= '0;
      haltreq_q      <= 1'b0;
      hartsel_q      <= '0;
      ndmreset_q     <= 1'b0;
      dmactive_q     <= 1'b0;
      sbreadonaddr_q <= 1'b0;
      sbautoinc_q    <= 1'b0;
      sbreadondata_q <= 1'b0;
      sberror_q      <= 1'b0;
      sba_start_q    <= 1'b0;
    end else begin
      resp_valid_q <= dmi_req_valid_i;
      resp_q.data  <= is_read ? rdata : '0;
      resp_q.error <= (is_read || is_write) && (addr_err || collide);
      sba_start_q  <= sba_kick && !collide;
      if (collide) begin
        sberror_q <= 1'b1;
      end
      if (is_write && (dmi_req_i.addr == AddrDmcontrol)) begin
        haltreq_q  <= dmi_req_i.data[31];
        hartsel_q  <= dmi_req_i.data[17:16];
        ndmreset_q <= dmi_req_i.data[1];
        dmactive_q <= dmi_req_i.data[0];
      end
      if (is_write && (dmi_req_i.addr == AddrSbcs)) begin
        sbreadonaddr_q <= dmi_req_i.data[20];
        sbautoinc_q    <= dmi_req_i.data[16];
        sbreadondata_q <= dmi_req_i.data[15];
        // write 1 to clear
        if (dmi_req_i.data[12]) begin
          sberror_q <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (sba_kick) begin
      sba_we_q    <= kick_we;
      sba_addr_q  <= kick_addr;
      sba_wdata_q <= kick_wdata;
    end
    if (sba_stat_i.done) begin
      sbdata_q <= sba_stat_i.rdata;
      if (sbautoinc_q) begin
        sbaddress_q <= sba_stat_i.next_addr;
      end
    end
    // a refused access leaves the registers untouched
    if (is_write && !collide) begin
      case (dmi_req_i.addr)
        AddrData0:      data0_q     <= dmi_req_i.data;
        AddrSbaddress0: sbaddress_q <= dmi_req_i.data;
        AddrSbdata0:    sbdata_q    <= dmi_req_i.data;
        default: ;
      endcase
    end
  end

  assign dmi_resp_valid_o        = resp_valid_q;
  assign dmi_resp_o              = resp_q;
  assign hartsel_o               = hartsel_q;
  assign haltreq_o               = haltreq_q;
  assign ndmreset_o              = ndmreset_q;
  assign sba_cmd_o.start         = sba_start_q;
  assign sba_cmd_o.we            = sba_we_q;
  assign sba_cmd_o.addr          = sba_addr_q;
  assign sba_cmd_o.wdata         = sba_wdata_q;
  assign sba_cmd_o.autoincrement = sbautoinc_q;

  // transport waits for the response before the next request
  a_dmi_no_overlap: assert property (@(posedge clk_i) disable iff (!rst_ni)
    dmi_req_valid_i |=> !dmi_req_valid_i);

endmodule

// File: source/halt_ctrl.sv
`timescale 1ns/10ps

module halt_ctrl (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  dbg_pkg::hart_sel_t hartsel_i,
  input  logic               haltreq_i,
  input  dbg_pkg::hart_vec_t halted_i,
  output dbg_pkg::hart_vec_t debug_req_o,
  output logic               anyhalted_o,
  output logic               allhalted_o
);
  import dbg_pkg::*;

  hart_vec_t halted_q;

  // halted comes from the cores, register it once
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      halted_q <= '0;
    end else begin
      halted_q <= halted_i;
    end
  end

  // only the selected hart is asked to halt, and only until it reports halted
  always_comb begin
    debug_req_o            = '0;
    debug_req_o[hartsel_i] = haltreq_i && !halted_q[hartsel_i];
  end

  // with a single selected hart any and all collapse to the same bit
  assign anyhalted_o = halted_q[hartsel_i];
  assign allhalted_o = halted_q[hartsel_i];

  a_single_debug_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(debug_req_o));

  // a hart that has reported halted gets no request in the next cycle
  a_halted_no_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (halted_i != '0) |=> ((debug_req_o & $past(halted_i)) == '0));

endmodule

// File: source/sba_engine.sv
`timescale 1ns/10ps

module sba_engine (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  dbg_pkg::sba_cmd_t  cmd_i,
  output dbg_pkg::sba_stat_t stat_o,
  output dbg_pkg::sbus_req_t sbus_req_o,
  input  logic               sbus_gnt_i,
  input  logic               sbus_rvalid_i,
  input  dbg_pkg::bus_word_t sbus_rdata_i
);
  import dbg_pkg::*;

  sba_state_e state_q;
  logic       done_q;
  logic       we_q;
  logic       autoinc_q;
  bus_word_t  addr_q;
  bus_word_t  data_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        IDLE: begin
          if (cmd_i.start) begin
            state_q <= REQUEST;
          end
        end
        REQUEST: begin
          // a write is complete with its grant
          if (sbus_gnt_i) begin
            if (we_q) begin
              state_q <= IDLE;
              done_q  <= 1'b1;
            end else begin
              state_q <= WAIT_RVALID;
            end
          end
        end
        WAIT_RVALID: begin
          if (sbus_rvalid_i) begin
            state_q <= IDLE;
            done_q  <= 1'b1;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // data_q holds write data first and read data after rvalid
  always_ff @(posedge clk_i) begin
    if ((state_q == IDLE) && cmd_i.start) begin
      we_q      <= cmd_i.we;
      autoinc_q <= cmd_i.autoincrement;
      addr_q    <= cmd_i.addr;
      data_q    <= cmd_i.wdata;
    end else if ((state_q == WAIT_RVALID) && sbus_rvalid_i) begin
      data_q <= sbus_rdata_i;
    end
  end

  assign sbus_req_o.req   = (state_q == REQUEST);
  assign sbus_req_o.we    = we_q;
  assign sbus_req_o.addr  = addr_q;
  assign sbus_req_o.be    = '1;
  assign sbus_req_o.wdata = data_q;

  // busy covers the done cycle so sbdata0 is captured before sbbusy drops
  assign stat_o.busy      = (state_q != IDLE) || done_q;
  assign stat_o.done      = done_q;
  assign stat_o.rdata     = data_q;
  assign stat_o.next_addr = autoinc_q ? addr_q + BusWidth'(4) : addr_q;

  a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    sbus_req_o.req && !sbus_gnt_i |=> sbus_req_o.req && $stable(sbus_req_o));

  a_rvalid_expected: assert property (@(posedge clk_i) disable iff (!rst_ni)
    sbus_rvalid_i |-> state_q == WAIT_RVALID);

endmodule

// File: source/sys_rstgen.sv
`timescale 1ns/10ps

module sys_rstgen (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic ndmreset_i,
  input  logic test_en_i,
  output logic rst_no
);

  logic       rst_src_n;
  logic [1:0] sync_q;

  // in test mode only the external reset reaches the system
  assign rst_src_n = test_en_i ? rst_ni : (rst_ni & ~ndmreset_i);

  // assert right away, release after two clean edges
  always_ff @(posedge clk_i or negedge rst_src_n) begin
    if (!rst_src_n) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[0], 1'b1};
    end
  end

  assign rst_no = sync_q[1];

endmodule

// File: verification/dmi_stimulus.txt
# op addr data expect mask err name, all numbers hex
# ops W R P(poll) H(halted) D(debug_req) N(ndmreset_no) M(memory) G(hold grant) T(test_en)
W 10 00000001 00000000 00000000 0 dm_active
W 04 a5a55a5a 00000000 00000000 0 data0_write
R 04 00000000 a5a55a5a ffffffff 0 data0_read
R 11 00000000 00000002 0000000f 0 dmstatus_version
R 15 00000000 00000000 00000000 1 unknown_addr
W 10 80020001 00000000 00000000 0 haltreq_hart2
D 00 00000000 00000004 0000000f 0 debug_req_hart2
H 00 00000004 00000000 00000000 0 hart2_halts
D 00 00000000 00000000 0000000f 0 debug_req_dropped
R 11 00000000 00000300 00000300 0 dmstatus_halted
W 10 80010001 00000000 00000000 0 select_hart1
R 11 00000000 00000000 00000300 0 dmstatus_running
D 00 00000000 00000002 0000000f 0 debug_req_hart1
W 10 00000001 00000000 00000000 0 haltreq_clear
W 38 00000000 00000000 00000000 0 sbcs_plain
W 39 00000010 00000000 00000000 0 sbaddr_write
W 3c cafef00d 00000000 00000000 0 sbdata_write
P 38 00000000 00000000 00200000 0 sb_write_idle
M 10 00000000 cafef00d ffffffff 0 mem_write
W 38 00100000 00000000 00000000 0 sbcs_readonaddr
W 39 00000018 00000000 00000000 0 sbaddr_read_fill
P 38 00000000 00000000 00200000 0 sb_fill_idle
R 3c 00000000 c0de0606 ffffffff 0 sbdata_fill
W 39 00000010 00000000 00000000 0 sbaddr_read_back
P 38 00000000 00000000 00200000 0 sb_read_back_idle
R 3c 00000000 cafef00d ffffffff 0 sbdata_read_back
W 38 00010000 00000000 00000000 0 sbcs_autoinc
W 39 00000020 00000000 00000000 0 autoinc_base
W 3c 11111111 00000000 00000000 0 autoinc_first
P 38 00000000 00000000 00200000 0 autoinc_first_idle
W 3c 22222222 00000000 00000000 0 autoinc_second
P 38 00000000 00000000 00200000 0 autoinc_second_idle
R 39 00000000 00000028 ffffffff 0 autoinc_addr
M 20 00000000 11111111 ffffffff 0 mem_autoinc_a
M 24 00000000 22222222 ffffffff 0 mem_autoinc_b
G 00 00000001 00000000 00000000 0 grant_hold
W 38 00000000 00000000 00000000 0 sbcs_collide
W 39 00000030 00000000 00000000 0 collide_addr
W 3c 33333333 00000000 00000000 0 collide_first
W 3c 44444444 00000000 00000000 1 collide_second
R 38 00000000 00201000 00201000 0 sbcs_busy_error
G 00 00000000 00000000 00000000 0 grant_release
P 38 00000000 00000000 00200000 0 collide_idle
M 30 00000000 33333333 ffffffff 0 mem_collide
W 38 00001000 00000000 00000000 0 sberror_clear
R 38 00000000 00000000 00001000 0 sberror_cleared
W 10 00000003 00000000 00000000 0 ndmreset_set
N 00 00000000 00000000 00000001 0 ndmreset_low
W 10 00000001 00000000 00000000 0 ndmreset_clear
N 00 00000000 00000001 00000001 0 ndmreset_high
T 00 00000001 00000000 00000000 0 test_mode_on
W 10 00000003 00000000 00000000 0 ndmreset_test_mode
N 00 00000000 00000001 00000001 0 ndmreset_bypassed

// File: verification/tb_debug_system.sv
`timescale 1ns/10ps

module tb_debug_system;
  import dbg_pkg::*;

  logic               clk_i = 1'b0;
  logic               rst_ni;
  logic               test_en_i;
  logic               dmi_req_valid_i;
  dmi_req_t           dmi_req_i;
  logic               dmi_resp_valid_o;
  dmi_resp_t          dmi_resp_o;
  hart_vec_t          halted_i;
  hart_vec_t          debug_req_o;
  sbus_req_t          sbus_req_o;
  logic               sbus_gnt_i;
  logic               sbus_rvalid_i;
  bus_word_t          sbus_rdata_i;
  logic               ndmreset_no;
  // 64-word memory behind the system bus
  bus_word_t          mem [64];
  logic               hold_gnt;
  int                 op_count;
  bit                 ops_counted;

  debug_system DUT (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .test_en_i        (test_en_i),
    .dmi_req_valid_i  (dmi_req_valid_i),
    .dmi_req_i        (dmi_req_i),
    .dmi_resp_valid_o (dmi_resp_valid_o),
    .dmi_resp_o       (dmi_resp_o),
    .halted_i         (halted_i),
    .debug_req_o      (debug_req_o),
    .sbus_req_o       (sbus_req_o),
    .sbus_gnt_i       (sbus_gnt_i),
    .sbus_rvalid_i    (sbus_rvalid_i),
    .sbus_rdata_i     (sbus_rdata_i),
    .ndmreset_no      (ndmreset_no)
  );

  always #10 clk_i = ~clk_i;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "run aborted");
  endtask

  task automatic check_value(input string name, input bus_word_t exp, input bus_word_t act);
    if (exp !== act) begin
      $display("[FAIL] %s expected %h actual %h", name, exp, act);
      abort_run("value mismatch");
    end
  endtask

  // one DMI request, response expected exactly one cycle later
  task automatic dmi_access(input dmi_op_e op, input dmi_addr_t addr, input bus_word_t data,
                            output dmi_resp_t resp);
    @(posedge clk_i);
    #2;
    if (dmi_resp_valid_o) begin
      abort_run("DMI response strobe seen without a pending request");
    end
    dmi_req_valid_i = 1'b1;
    dmi_req_i.op    = op;
    dmi_req_i.addr  = addr;
    dmi_req_i.data  = data;
    @(posedge clk_i);
    #2;
    dmi_req_valid_i = 1'b0;
    dmi_req_i       = '0;
    if (!dmi_resp_valid_o) begin
      abort_run("DMI response strobe missing one cycle after the request");
    end
    resp = dmi_resp_o;
  endtask

  // status 0 at end of file, 1 for an operation, 2 for a broken line
  task automatic read_op(input int fd, output int status, output byte op,
                         output bus_word_t a, output bus_word_t d, output bus_word_t e,
                         output bus_word_t m, output logic er, output string nm);
    int code;
    int ch;
    status = 0;
    code = $fscanf(fd, " %c", op);
    while (code == 1 && op == "#") begin
      ch = $fgetc(fd);
      while (ch != 10 && ch != -1) begin
        ch = $fgetc(fd);
      end
      code = $fscanf(fd, " %c", op);
    end
    if (code == 1) begin
      code   = $fscanf(fd, "%h %h %h %h %h %s", a, d, e, m, er, nm);
      status = (code == 6) ? 1 : 2;
    end
  endtask

  task automatic run_op(input byte op, input bus_word_t a, input bus_word_t d,
                        input bus_word_t e, input bus_word_t m, input logic er,
                        input string nm);
    dmi_resp_t resp;
    bit        matched;
    int        tries;
    case (op)
      "W": begin
        dmi_access(WRITE, a[6:0], d, resp);
        check_value(nm, '0, resp.data);
        check_value({nm, "_error"}, 32'(er), 32'(resp.error));
      end
      "R": begin
        dmi_access(READ, a[6:0], '0, resp);
        check_value(nm, e & m, resp.data & m);
        check_value({nm, "_error"}, 32'(er), 32'(resp.error));
      end
      "P": begin
        matched = 1'b0;
        for (int t = 0; t < 50 && !matched; t++) begin
          dmi_access(READ, a[6:0], '0, resp);
          matched = ((resp.data & m) == (e & m));
        end
        if (!matched) begin
          abort_run({"poll ", nm, " did not match within 50 reads"});
        end
      end
      "H": begin
        @(posedge clk_i);
        #2;
        halted_i = d[3:0];
      end
      // away from the bus model's sampling point
      "G": begin
        @(negedge clk_i);
        hold_gnt = d[0];
      end
      "T": begin
        @(posedge clk_i);
        #2;
        test_en_i = d[0];
      end
      "D": begin
        @(posedge clk_i);
        #2;
        check_value(nm, e & m, 32'(debug_req_o) & m);
      end
      "N": begin
        // the synchronizer needs a few edges, so wait for the level first
        tries = 0;
        @(posedge clk_i);
        #2;
        while (ndmreset_no !== e[0] && tries < 50) begin
          @(posedge clk_i);
          #2;
          tries++;
        end
        check_value(nm, e, 32'(ndmreset_no));
      end
      "M": check_value(nm, e & m, mem[a[7:2]] & m);
      default: abort_run({"unknown stimulus operation in line ", nm});
    endcase
  endtask

  // memory model with random grant and rvalid latency
  initial begin : bus_model
    int        gnt_wait;
    int        rv_wait;
    logic      rd_pending;
    bus_word_t rd_word;
    void'($urandom(32'hefa1ae41));
    sbus_gnt_i    = 1'b0;
    sbus_rvalid_i = 1'b0;
    sbus_rdata_i  = '0;
    gnt_wait      = -1;
    rv_wait       = 0;
    rd_pending    = 1'b0;
    rd_word       = '0;
    for (int i = 0; i < 64; i++) begin
      mem[i] = 32'hc0de0000 + i * 32'h101;
    end
    forever begin
      @(posedge clk_i);
      #2;
      sbus_gnt_i    = 1'b0;
      sbus_rvalid_i = 1'b0;
      if (rd_pending) begin
        if (rv_wait == 0) begin
          sbus_rvalid_i = 1'b1;
          sbus_rdata_i  = rd_word;
          rd_pending    = 1'b0;
        end else begin
          rv_wait--;
        end
      end
      // every access covers the whole word
      if (sbus_req_o.req) begin
        check_value("sbus_byte_enable", 32'h0000000f, 32'(sbus_req_o.be));
      end
      if (sbus_req_o.req && !hold_gnt) begin
        if (gnt_wait < 0) begin
          gnt_wait = int'($urandom % 4);
        end
        if (gnt_wait == 0) begin
          sbus_gnt_i = 1'b1;
          gnt_wait   = -1;
          if (sbus_req_o.we) begin
            mem[sbus_req_o.addr[7:2]] = sbus_req_o.wdata;
          end else begin
            rd_pending = 1'b1;
            rd_word    = mem[sbus_req_o.addr[7:2]];
            rv_wait    = int'($urandom % 3);
          end
        end else begin
          gnt_wait--;
        end
      end
    end
  end

  initial begin : watchdog
    wait (ops_counted);
    repeat (op_count * 200 + 20) @(posedge clk_i);
    abort_run("watchdog expired before the stimulus was finished");
  end

  initial begin : main
    int        fd;
    int        status;
    byte       op;
    bus_word_t a;
    bus_word_t d;
    bus_word_t e;
    bus_word_t m;
    logic      er;
    string     nm;
    rst_ni          = 1'b0;
    test_en_i       = 1'b0;
    dmi_req_valid_i = 1'b0;
    dmi_req_i       = '0;
    halted_i        = '0;
    hold_gnt        = 1'b0;
    op_count        = 0;
    ops_counted     = 1'b0;

    // count the operations first so the watchdog can size its limit
    fd = $fopen("verification/dmi_stimulus.txt", "r");
    if (fd == 0) begin
      abort_run("cannot open the stimulus file");
    end
    status = 1;
    while (status == 1) begin
      read_op(fd, status, op, a, d, e, m, er, nm);
      if (status == 1) begin
        op_count++;
      end
    end
    $fclose(fd);
    if (op_count == 0) begin
      abort_run("stimulus file holds no operations");
    end
    ops_counted = 1'b1;

    repeat (2) @(posedge clk_i);
    #2;
    check_value("reset_outputs", '0,
                32'({debug_req_o, dmi_resp_valid_o, sbus_req_o.req, ndmreset_no}));
    repeat (14) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    repeat (4) @(posedge clk_i);

    fd = $fopen("verification/dmi_stimulus.txt", "r");
    read_op(fd, status, op, a, d, e, m, er, nm);
    while (status == 1) begin
      run_op(op, a, d, e, m, er, nm);
      read_op(fd, status, op, a, d, e, m, er, nm);
    end
    if (status == 2) begin
      abort_run({"malformed stimulus line after ", nm});
    end
    $fclose(fd);
    $display("Simulation passed");
    $finish;
  end

endmodule
